//--- list.f
src/j1_io_pkg.sv
src/periph_regs_pkg.sv
src/io_ctrl.sv
src/peripheral_mult.sv
src/peripheral_div.sv
src/peripheral_uart.sv
src/io_ram.sv
src/j1_io_top.sv
verification/j1_io_chk.sv
verification/tb_j1_io.sv

//--- run.sh
#!/bin/sh
# build the j1 io testbench with verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_j1_io -o sim_j1_io \
  && ./obj_dir/sim_j1_io > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation passed"; exit 0; }

//--- verification/tb_j1_io.sv
module tb_j1_io;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLKS_PER_BIT = 4;
  localparam int CLK_NS       = 100;
  localparam int BIT_NS       = CLKS_PER_BIT * CLK_NS;
  localparam int N_MULT       = 50;
  localparam int N_DIV        = 40;
  localparam int N_RAM        = 32;
  localparam int N_UART       = 8;
  localparam int POLL_MAX     = 64;   // status reads before giving up
  // worst case clock cycles per test, a strobe costs two cycles
  localparam int MULT_CYC = N_MULT * 4 * 2;
  localparam int DIV_CYC  = N_DIV * (4 + POLL_MAX) * 2;
  localparam int RAM_CYC  = (2 * N_RAM + 3) * 2;
  localparam int UART_CYC = (N_UART + 2) * (POLL_MAX * 2 + 4) + 4 * CLKS_PER_BIT;
  localparam int WATCHDOG_NS = (10 + MULT_CYC + DIV_CYC + RAM_CYC + UART_CYC + 500) * CLK_NS;

  logic        sys_clk = 1'b0;
  logic        arst_n;
  logic [15:0] io_addr;
  logic [15:0] io_dout;
  logic        io_rd;
  logic        io_wr;
  logic [15:0] io_din;
  logic        uart_tx;
  integer      seed = 32'h922e4753;
  int          err_data = 0;       // wrong values
  int          err_other = 0;      // timeouts and framing
  logic [15:0] ram_model [256];
  logic [7:0]  rx_bytes [$];       // filled by the serial monitor

  always #(CLK_NS / 2) sys_clk = ~sys_clk;

  j1_io_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_dut (
    .sys_clk_i (sys_clk),
    .arst_n_i  (arst_n),
    .io_addr_i (io_addr),
    .io_dout_i (io_dout),
    .io_rd_i   (io_rd),
    .io_wr_i   (io_wr),
    .io_din_o  (io_din),
    .uart_tx_o (uart_tx)
  );

  function automatic logic [15:0] reg_addr(input logic [7:0] page, input logic [3:0] ofs);
    return {page, 4'h0, ofs};
  endfunction

  task automatic io_write(input logic [15:0] addr, input logic [15:0] data);
    @(posedge sys_clk);
    #5;
    io_addr = addr;
    io_dout = data;
    io_wr   = 1'b1;
    @(posedge sys_clk);   // write lands here
    #5;
    io_wr = 1'b0;
  endtask

  task automatic io_read(input logic [15:0] addr, output logic [15:0] data);
    @(posedge sys_clk);
    #5;
    io_addr = addr;
    io_rd   = 1'b1;
    @(posedge sys_clk);   // io_din loads here
    #5;
    io_rd = 1'b0;
    data  = io_din;
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    err_data++;
    $display("[FAIL] %s expected %04h actual %04h", name, exp, act);
  endtask

  // poll bit 0 of a status register
  task automatic wait_idle(input logic [15:0] status_addr, input string name);
    logic [15:0] st;
    int          tries;
    st    = 16'h0001;
    tries = 0;
    while (st[0] && tries < POLL_MAX)
    begin
      io_read(status_addr, st);
      tries++;
    end
    if (st[0])
    begin
      err_other++;
      $display("%s: busy flag still set after %0d status reads", name, POLL_MAX);
    end
  endtask

  // rebuild bytes from the line, sampled mid-bit
  always
  begin : serial_monitor
    logic [7:0] b;
    @(negedge uart_tx);
    #(BIT_NS / 2);
    if (uart_tx !== 1'b0)
    begin
      err_other++;
      $display("serial monitor: start bit not low in its middle");
    end
    for (int i = 0; i < 8; i++)
    begin
      #(BIT_NS);
      b[i] = uart_tx;   // lsb first
    end
    #(BIT_NS);
    if (uart_tx !== 1'b1)
    begin
      err_other++;
      $display("serial monitor: stop bit not high");
    end
    rx_bytes.push_back(b);
  end

  initial
  begin : main
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] rd;
    logic [15:0] exp_q;
    logic [15:0] exp_r;
    logic [31:0] prod;
    logic [7:0]  ram_a;
    logic [7:0]  addr_list [$];
    logic [7:0]  sent [$];
    int          idx;
    io_addr = '0;
    io_dout = '0;
    io_rd   = 1'b0;
    io_wr   = 1'b0;
    arst_n  = 1'b0;
    repeat (3) @(posedge sys_clk);
    #5;
    arst_n = 1'b1;

    // reset state
    io_read(reg_addr(j1_io_pkg::PAGE_DIV, periph_regs_pkg::DIV_STATUS), rd);
    if (rd !== 16'h0000) report_mismatch("reset div status", 16'h0000, rd);
    io_read(reg_addr(j1_io_pkg::PAGE_UART, periph_regs_pkg::UART_STATUS), rd);
    if (rd !== 16'h0000) report_mismatch("reset uart status", 16'h0000, rd);
    if (uart_tx !== 1'b1) report_mismatch("reset uart line", 16'h0001, {15'h0, uart_tx});

    for (int i = 0; i < N_MULT; i++)
    begin
      a    = $random(seed);
      b    = $random(seed);
      prod = 32'(a) * 32'(b);
      io_write(reg_addr(j1_io_pkg::PAGE_MULT, periph_regs_pkg::MULT_A), a);
      io_write(reg_addr(j1_io_pkg::PAGE_MULT, periph_regs_pkg::MULT_B), b);
      io_read(reg_addr(j1_io_pkg::PAGE_MULT, periph_regs_pkg::MULT_LO), rd);
      if (rd !== prod[15:0]) report_mismatch("mult lo", prod[15:0], rd);
      io_read(reg_addr(j1_io_pkg::PAGE_MULT, periph_regs_pkg::MULT_HI), rd);
      if (rd !== prod[31:16]) report_mismatch("mult hi", prod[31:16], rd);
    end

    for (int i = 0; i < N_DIV; i++)
    begin
      a = $random(seed);
      if (i % 8 == 3)
        b = 16'h0000;                 // divide by zero case
      else if (i % 2 == 1)
        b = $random(seed) & 16'h00ff; // small divisors, big quotients
      else
        b = $random(seed);
      if (b == 16'h0000)
      begin
        exp_q = 16'hffff;
        exp_r = a;
      end
      else
      begin
        exp_q = a / b;
        exp_r = a % b;
      end
      io_write(reg_addr(j1_io_pkg::PAGE_DIV, periph_regs_pkg::DIV_DIVIDEND), a);
      io_write(reg_addr(j1_io_pkg::PAGE_DIV, periph_regs_pkg::DIV_DIVISOR), b);
      wait_idle(reg_addr(j1_io_pkg::PAGE_DIV, periph_regs_pkg::DIV_STATUS), "div poll");
      io_read(reg_addr(j1_io_pkg::PAGE_DIV, periph_regs_pkg::DIV_QUOT), rd);
      if (rd !== exp_q) report_mismatch("div quotient", exp_q, rd);
      io_read(reg_addr(j1_io_pkg::PAGE_DIV, periph_regs_pkg::DIV_REM), rd);
      if (rd !== exp_r) report_mismatch("div remainder", exp_r, rd);
    end

    for (int i = 0; i < N_RAM; i++)
    begin
      ram_a = $random(seed);
      a     = $random(seed);
      io_write({j1_io_pkg::PAGE_RAM, ram_a}, a);
      ram_model[ram_a] = a;           // repeated addresses keep the last value
      addr_list.push_back(ram_a);
    end
    for (int i = 0; i < N_RAM; i++)
    begin
      idx   = $unsigned($random(seed)) % addr_list.size();
      ram_a = addr_list[idx];
      io_read({j1_io_pkg::PAGE_RAM, ram_a}, rd);
      if (rd !== ram_model[ram_a]) report_mismatch("ram readback", ram_model[ram_a], rd);
    end
    io_read(16'h1234, rd);            // page 0x12 is a hole
    if (rd !== 16'h0666) report_mismatch("unmapped read", 16'h0666, rd);

    for (int i = 0; i < N_UART; i++)
    begin
      wait_idle(reg_addr(j1_io_pkg::PAGE_UART, periph_regs_pkg::UART_STATUS), "uart poll");
      a = $random(seed);
      io_write(reg_addr(j1_io_pkg::PAGE_UART, periph_regs_pkg::UART_DATA), {8'h00, a[7:0]});
      sent.push_back(a[7:0]);
      if (i == 3)   // lands mid frame, must vanish
        io_write(reg_addr(j1_io_pkg::PAGE_UART, periph_regs_pkg::UART_DATA), 16'h00a5);
    end
    wait_idle(reg_addr(j1_io_pkg::PAGE_UART, periph_regs_pkg::UART_STATUS), "uart poll");
    #(2 * BIT_NS);
    if (rx_bytes.size() != N_UART)
      report_mismatch("uart frame count", 16'(N_UART), 16'(rx_bytes.size()));
    for (int i = 0; i < N_UART && i < rx_bytes.size(); i++)
    begin
      if (rx_bytes[i] !== sent[i]) report_mismatch("uart byte", {8'h00, sent[i]},
                                                   {8'h00, rx_bytes[i]});
    end

    $display("closing: %0d value errors, %0d other errors", err_data, err_other);
    if (err_data + err_other == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule

//--- verification/j1_io_chk.sv
module j1_io_chk (
  input logic                              sys_clk_i,
  input logic                              arst_n_i,
  input logic                              mult_sel_i,
  input logic                              div_sel_i,
  input logic                              uart_sel_i,
  input logic                              ram_sel_i,
  input logic                              io_wr_i,
  input logic [j1_io_pkg::ADDR_W-1:0]      io_addr_i,
  input logic                              div_busy_i,
  input logic                              uart_busy_i,
  input logic                              uart_tx_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic       div_start;   // accepted divisor write
  logic [4:0] busy_len;    // consecutive busy cycles so far
  logic [3:0] sel_exp;     // mult, div, uart, ram from the address map

  assign div_start = div_sel_i & io_wr_i & !div_busy_i
                   & (io_addr_i[periph_regs_pkg::OFS_W-1:0] == periph_regs_pkg::DIV_DIVISOR);

  // upper byte to select, none for a hole
  always_comb
  begin
    case (io_addr_i[15:8])
      8'h67:   sel_exp = 4'b1000;
      8'h68:   sel_exp = 4'b0100;
      8'h69:   sel_exp = 4'b0010;
      8'h70:   sel_exp = 4'b0001;
      default: sel_exp = 4'b0000;
    endcase
  end

  always_ff @(posedge sys_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      busy_len <= '0;
    else if (div_busy_i)
      busy_len <= busy_len + 1'b1;
    else
      busy_len <= '0;   // restart on every idle cycle
  end

  // at most one select, and only the one of the addressed page
  sel_decode: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
    {mult_sel_i, div_sel_i, uart_sel_i, ram_sel_i} == sel_exp)
    else $error("peripheral selects do not match the addressed page");

  div_starts: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
    div_start |=> div_busy_i)
    else $error("divider busy did not rise after a divisor write");

  // one quotient bit per busy cycle
  div_len: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
    $fell(div_busy_i) |-> (busy_len == 5'd16))
    else $error("divider busy did not last 16 cycles");

  tx_idle: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
    !uart_busy_i |-> uart_tx_i)
    else $error("serial line low while the uart is idle");

endmodule

bind j1_io_top j1_io_chk u_chk (
  .sys_clk_i   (sys_clk_i),
  .arst_n_i    (arst_n_i),
  .mult_sel_i  (mult_sel),
  .div_sel_i   (div_sel),
  .uart_sel_i  (uart_sel),
  .ram_sel_i   (ram_sel),
  .io_wr_i     (io_wr_i),
  .io_addr_i   (io_addr_i),
  .div_busy_i  (div_busy),
  .uart_busy_i (u_uart.busy),
  .uart_tx_i   (uart_tx_o)
);

//--- src/j1_io_top.sv
module j1_io_top #(
  parameter int CLKS_PER_BIT = 868   // 100 MHz / 115200
) (
  input  logic                          sys_clk_i,
  input  logic                          arst_n_i,
  input  logic [j1_io_pkg::ADDR_W-1:0]  io_addr_i,
  input  logic [j1_io_pkg::DATA_W-1:0]  io_dout_i,   // cpu write data
  input  logic                          io_rd_i,
  input  logic                          io_wr_i,
  output logic [j1_io_pkg::DATA_W-1:0]  io_din_o,    // cpu read data
  output logic                          uart_tx_o
);

  logic                          mult_sel;
  logic                          div_sel;
  logic                          uart_sel;
  logic                          ram_sel;
  logic [j1_io_pkg::DATA_W-1:0]  mult_rdata;
  logic [j1_io_pkg::DATA_W-1:0]  div_rdata;
  logic [j1_io_pkg::DATA_W-1:0]  uart_rdata;
  logic [j1_io_pkg::DATA_W-1:0]  ram_rdata;
  logic                          div_busy;   // watched by the bound checker

  io_ctrl u_ctrl (
    .sys_clk_i    (sys_clk_i),
    .arst_n_i     (arst_n_i),
    .io_addr_i    (io_addr_i),
    .io_rd_i      (io_rd_i),
    .mult_rdata_i (mult_rdata),
    .div_rdata_i  (div_rdata),
    .uart_rdata_i (uart_rdata),
    .ram_rdata_i  (ram_rdata),
    .mult_sel_o   (mult_sel),
    .div_sel_o    (div_sel),
    .uart_sel_o   (uart_sel),
    .ram_sel_o    (ram_sel),
    .io_din_o     (io_din_o)
  );

  peripheral_mult u_mult (
    .sys_clk_i (sys_clk_i),
    .arst_n_i  (arst_n_i),
    .sel_i     (mult_sel),
    .io_wr_i   (io_wr_i),
    .addr_i    (io_addr_i[periph_regs_pkg::OFS_W-1:0]),
    .wdata_i   (io_dout_i),
    .rdata_o   (mult_rdata)
  );

  peripheral_div u_div (
    .sys_clk_i (sys_clk_i),
    .arst_n_i  (arst_n_i),
    .sel_i     (div_sel),
    .io_wr_i   (io_wr_i),
    .addr_i    (io_addr_i[periph_regs_pkg::OFS_W-1:0]),
    .wdata_i   (io_dout_i),
    .rdata_o   (div_rdata),
    .busy_o    (div_busy)
  );

  peripheral_uart #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart (
    .sys_clk_i (sys_clk_i),
    .arst_n_i  (arst_n_i),
    .sel_i     (uart_sel),
    .io_wr_i   (io_wr_i),
    .addr_i    (io_addr_i[periph_regs_pkg::OFS_W-1:0]),
    .wdata_i   (io_dout_i),
    .rdata_o   (uart_rdata),
    .uart_tx_o (uart_tx_o)
  );

  io_ram u_ram (
    .sys_clk_i (sys_clk_i),
    .sel_i     (ram_sel),
    .io_wr_i   (io_wr_i),
    .addr_i    (io_addr_i[periph_regs_pkg::RAM_AW-1:0]),   // full low byte
    .wdata_i   (io_dout_i),
    .rdata_o   (ram_rdata)
  );

endmodule

//--- src/io_ram.sv
module io_ram (
  input  logic                               sys_clk_i,
  input  logic                               sel_i,
  input  logic                               io_wr_i,
  input  logic [periph_regs_pkg::RAM_AW-1:0] addr_i,
  input  logic [j1_io_pkg::DATA_W-1:0]       wdata_i,
  output logic [j1_io_pkg::DATA_W-1:0]       rdata_o
);

  localparam int DEPTH = 2 ** periph_regs_pkg::RAM_AW;  // 256 words

  logic [j1_io_pkg::DATA_W-1:0] mem [DEPTH];   // contents undefined until written

  // single port, bus writes only
  always_ff @(posedge sys_clk_i)
  begin
    if (sel_i && io_wr_i)
      mem[addr_i] <= wdata_i;
  end

  // async read, io_ctrl holds the register stage
  assign rdata_o = mem[addr_i];

endmodule

//--- src/peripheral_uart.sv
module peripheral_uart #(
  parameter int CLKS_PER_BIT = 868   // sys clocks per serial bit
) (
  input  logic                              sys_clk_i,
  input  logic                              arst_n_i,
  input  logic                              sel_i,
  input  logic                              io_wr_i,
  input  logic [periph_regs_pkg::OFS_W-1:0] addr_i,
  input  logic [j1_io_pkg::DATA_W-1:0]      wdata_i,
  output logic [j1_io_pkg::DATA_W-1:0]      rdata_o,
  output logic                              uart_tx_o
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  periph_regs_pkg::uart_state_e  state;
  logic [CNT_W-1:0]              baud_cnt;
  logic [2:0]                    bit_idx;    // data bit being sent
  logic [7:0]                    shift_q;    // lsb goes out first
  logic                          tx_q;
  logic                          busy;
  logic                          bit_end;    // last clock of the current bit
  logic                          start_frame;

  assign busy        = (state != periph_regs_pkg::TX_IDLE);
  assign bit_end     = (baud_cnt == CNT_W'(CLKS_PER_BIT-1));
  assign start_frame = sel_i & io_wr_i & !busy & (addr_i == periph_regs_pkg::UART_DATA);
  assign uart_tx_o   = tx_q;

  always_ff @(posedge sys_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state    <= periph_regs_pkg::TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      shift_q  <= '0;
      tx_q     <= 1'b1;                           // line idles high
    end
    else
    begin
      baud_cnt <= (busy && !bit_end) ? baud_cnt + 1'b1 : '0;
      case (state)
        periph_regs_pkg::TX_IDLE:
        begin
          if (start_frame)
          begin
            shift_q <= wdata_i[7:0];
            tx_q    <= 1'b0;                      // start bit
            state   <= periph_regs_pkg::TX_START;
          end
        end
        periph_regs_pkg::TX_START:
        begin
          if (bit_end)
          begin
            tx_q    <= shift_q[0];
            bit_idx <= '0;
            state   <= periph_regs_pkg::TX_DATA;
          end
        end
        periph_regs_pkg::TX_DATA:
        begin
          if (bit_end)
          begin
            shift_q <= shift_q >> 1;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
            begin
              tx_q  <= 1'b1;                      // stop bit
              state <= periph_regs_pkg::TX_STOP;
            end
            else
              tx_q <= shift_q[1];                 // next bit after the shift
          end
        end
        default:                                  // stop
        begin
          if (bit_end)
            state <= periph_regs_pkg::TX_IDLE;    // busy drops here
        end
      endcase
    end
  end

  // data register is write only
  always_comb
  begin
    if (addr_i == periph_regs_pkg::UART_STATUS)
      rdata_o = {{(j1_io_pkg::DATA_W-1){1'b0}}, busy};
    else
      rdata_o = '0;
  end

endmodule

//--- src/peripheral_div.sv
module peripheral_div (
  input  logic                              sys_clk_i,
  input  logic                              arst_n_i,
  input  logic                              sel_i,
  input  logic                              io_wr_i,
  input  logic [periph_regs_pkg::OFS_W-1:0] addr_i,
  input  logic [j1_io_pkg::DATA_W-1:0]      wdata_i,
  output logic [j1_io_pkg::DATA_W-1:0]      rdata_o,
  output logic                              busy_o
);

  localparam int W = j1_io_pkg::DATA_W;

  periph_regs_pkg::div_state_e  state;
  logic                         wr_en;
  logic [$clog2(W)-1:0]         bit_cnt;     // one quotient bit per cycle
  logic [W-1:0]                 dividend_q;
  logic [W-1:0]                 divisor_q;
  logic [W-1:0]                 quot_q;      // dividend shifts out, quotient shifts in
  logic [W-1:0]                 rem_q;
  logic [W:0]                   trial;       // partial remainder with next dividend bit
  logic [W:0]                   diff;

  assign wr_en  = sel_i & io_wr_i & (state == periph_regs_pkg::DIV_IDLE);  // dropped while busy
  assign busy_o = (state == periph_regs_pkg::DIV_RUN);

  assign trial = {rem_q, quot_q[W-1]};
  assign diff  = trial - {1'b0, divisor_q};  // msb set means it did not fit

  // control
  always_ff @(posedge sys_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state   <= periph_regs_pkg::DIV_IDLE;
      bit_cnt <= '0;
    end
    else if (wr_en && addr_i == periph_regs_pkg::DIV_DIVISOR)
    begin
      state   <= periph_regs_pkg::DIV_RUN;
      bit_cnt <= '0;
    end
    else if (busy_o)
    begin
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == $clog2(W)'(W-1))
        state <= periph_regs_pkg::DIV_IDLE;  // last step lands with busy falling
    end
  end

  // datapath, restoring shift-subtract
  always_ff @(posedge sys_clk_i)
  begin
    if (wr_en && addr_i == periph_regs_pkg::DIV_DIVIDEND)
      dividend_q <= wdata_i;
    if (wr_en && addr_i == periph_regs_pkg::DIV_DIVISOR)
    begin
      divisor_q <= wdata_i;
      quot_q    <= dividend_q;
      rem_q     <= '0;
    end
    else if (busy_o)
    begin
      if (!diff[W])
      begin
        rem_q  <= diff[W-1:0];           // divisor fits, keep the difference
        quot_q <= {quot_q[W-2:0], 1'b1};
      end
      else
      begin
        rem_q  <= trial[W-1:0];          // restore
        quot_q <= {quot_q[W-2:0], 1'b0};
      end
    end
  end

  // divisor zero always fits, so quotient ends all ones and rem = dividend

  always_comb
  begin
    case (addr_i)
      periph_regs_pkg::DIV_DIVIDEND: rdata_o = dividend_q;
      periph_regs_pkg::DIV_DIVISOR:  rdata_o = divisor_q;
      periph_regs_pkg::DIV_STATUS:   rdata_o = {{(W-1){1'b0}}, busy_o};
      periph_regs_pkg::DIV_QUOT:     rdata_o = quot_q;
      periph_regs_pkg::DIV_REM:      rdata_o = rem_q;
      default:                       rdata_o = '0;
    endcase
  end

endmodule

//--- src/peripheral_mult.sv
module peripheral_mult (
  input  logic                              sys_clk_i,
  input  logic                              arst_n_i,
  input  logic                              sel_i,
  input  logic                              io_wr_i,
  input  logic [periph_regs_pkg::OFS_W-1:0] addr_i,
  input  logic [j1_io_pkg::DATA_W-1:0]      wdata_i,
  output logic [j1_io_pkg::DATA_W-1:0]      rdata_o
);

  logic                            wr_en;
  logic [j1_io_pkg::DATA_W-1:0]    op_a;
  logic [j1_io_pkg::DATA_W-1:0]    op_b;
  logic [2*j1_io_pkg::DATA_W-1:0]  product;   // full 32 bit result

  assign wr_en = sel_i & io_wr_i;  // only our page

  // operand registers
  always_ff @(posedge sys_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      op_a <= '0;
      op_b <= '0;
    end
    else if (wr_en)
    begin
      if (addr_i == periph_regs_pkg::MULT_A)
        op_a <= wdata_i;
      if (addr_i == periph_regs_pkg::MULT_B)
        op_b <= wdata_i;
    end
  end

  // product follows the operands one edge later, every cycle
  always_ff @(posedge sys_clk_i)
  begin
    product <= op_a * op_b;
  end

  always_comb
  begin
    case (addr_i)
      periph_regs_pkg::MULT_LO: rdata_o = product[j1_io_pkg::DATA_W-1:0];
      periph_regs_pkg::MULT_HI: rdata_o = product[2*j1_io_pkg::DATA_W-1:j1_io_pkg::DATA_W];
      default:                  rdata_o = '0;   // operands are write only
    endcase
  end

endmodule

//--- src/io_ctrl.sv
module io_ctrl (
  input  logic                           sys_clk_i,
  input  logic                           arst_n_i,
  input  logic [j1_io_pkg::ADDR_W-1:0]   io_addr_i,
  input  logic                           io_rd_i,
  input  logic [j1_io_pkg::DATA_W-1:0]   mult_rdata_i,
  input  logic [j1_io_pkg::DATA_W-1:0]   div_rdata_i,
  input  logic [j1_io_pkg::DATA_W-1:0]   uart_rdata_i,
  input  logic [j1_io_pkg::DATA_W-1:0]   ram_rdata_i,
  output logic                           mult_sel_o,
  output logic                           div_sel_o,
  output logic                           uart_sel_o,
  output logic                           ram_sel_o,
  output logic [j1_io_pkg::DATA_W-1:0]   io_din_o
);

  j1_io_pkg::periph_e                periph;   // decoded target
  logic [j1_io_pkg::PAGE_W-1:0]      page;
  logic [j1_io_pkg::DATA_W-1:0]      rd_mux;

  assign page = io_addr_i[j1_io_pkg::ADDR_W-1 -: j1_io_pkg::PAGE_W];

  // page decode
  always_comb
  begin
    case (page)
      j1_io_pkg::PAGE_MULT: periph = j1_io_pkg::PERIPH_MULT;
      j1_io_pkg::PAGE_DIV:  periph = j1_io_pkg::PERIPH_DIV;
      j1_io_pkg::PAGE_UART: periph = j1_io_pkg::PERIPH_UART;
      j1_io_pkg::PAGE_RAM:  periph = j1_io_pkg::PERIPH_RAM;
      default:              periph = j1_io_pkg::PERIPH_NONE;  // hole in the map
    endcase
  end

  // one select per page, never two at once
  assign mult_sel_o = (periph == j1_io_pkg::PERIPH_MULT);
  assign div_sel_o  = (periph == j1_io_pkg::PERIPH_DIV);
  assign uart_sel_o = (periph == j1_io_pkg::PERIPH_UART);
  assign ram_sel_o  = (periph == j1_io_pkg::PERIPH_RAM);

  always_comb
  begin
    case (periph)
      j1_io_pkg::PERIPH_MULT: rd_mux = mult_rdata_i;
      j1_io_pkg::PERIPH_DIV:  rd_mux = div_rdata_i;
      j1_io_pkg::PERIPH_UART: rd_mux = uart_rdata_i;
      j1_io_pkg::PERIPH_RAM:  rd_mux = ram_rdata_i;
      default:                rd_mux = j1_io_pkg::UNMAPPED_RD;
    endcase
  end

  // cpu sees read data one edge after the strobe, held until the next read
  always_ff @(posedge sys_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      io_din_o <= '0;
    else if (io_rd_i)
      io_din_o <= rd_mux;
  end

endmodule

//--- src/periph_regs_pkg.sv
package periph_regs_pkg;

  localparam int OFS_W  = 4;   // register offset bits seen by a peripheral
  localparam int RAM_AW = 8;   // ram word address bits

  // multiplier
  localparam logic [OFS_W-1:0] MULT_A  = 4'd0;
  localparam logic [OFS_W-1:0] MULT_B  = 4'd1;
  localparam logic [OFS_W-1:0] MULT_LO = 4'd2;
  localparam logic [OFS_W-1:0] MULT_HI = 4'd3;

  // divider, a divisor write kicks off the run
  localparam logic [OFS_W-1:0] DIV_DIVIDEND = 4'd0;
  localparam logic [OFS_W-1:0] DIV_DIVISOR  = 4'd1;
  localparam logic [OFS_W-1:0] DIV_STATUS   = 4'd2;  // bit 0 busy
  localparam logic [OFS_W-1:0] DIV_QUOT     = 4'd3;
  localparam logic [OFS_W-1:0] DIV_REM      = 4'd4;

  // uart tx, a data write starts a frame
  localparam logic [OFS_W-1:0] UART_DATA   = 4'd0;
  localparam logic [OFS_W-1:0] UART_STATUS = 4'd1;  // bit 0 busy

  typedef enum logic {DIV_IDLE, DIV_RUN} div_state_e;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_state_e;

endpackage

//--- src/j1_io_pkg.sv
package j1_io_pkg;

  // bus geometry of the j1 io port
  localparam int DATA_W = 16;
  localparam int ADDR_W = 16;
  localparam int PAGE_W = 8;   // upper address byte picks the peripheral

  // decoded target of the current bus address
  typedef enum logic [2:0]
  {
    PERIPH_NONE,
    PERIPH_MULT,
    PERIPH_DIV,
    PERIPH_UART,
    PERIPH_RAM
  } periph_e;

  // address map, upper byte only
  localparam logic [PAGE_W-1:0] PAGE_MULT = 8'h67;
  localparam logic [PAGE_W-1:0] PAGE_DIV  = 8'h68;
  localparam logic [PAGE_W-1:0] PAGE_UART = 8'h69;
  localparam logic [PAGE_W-1:0] PAGE_RAM  = 8'h70;

  // read value of an empty page
  // firmware checks for this pattern to find missing hardware
  localparam logic [DATA_W-1:0] UNMAPPED_RD = 16'h0666;

endpackage
